// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_dsp_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
BUILD_OPTS ?= --binary --timing -j 0
LINT_OPTS  ?= --lint-only -Wall --timing
PASS_MSG   ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_OPTS) --timescale $(TIMESCALE) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_OPTS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
logic/dsp_pkg.sv
logic/reset_sync.sv
logic/symbol_upsampler.sv
logic/fir_filter.sv
logic/coeff_bus_decode.sv
logic/iq_output_stage.sv
logic/dsp_top.sv
tb/tb_clock_gen.sv
tb/tb_dsp_top.sv

// ==== logic/coeff_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module coeff_bus_decode import dsp_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n_sync_wire,
    input  wire logic                         cfg_valid_i,
    input  wire logic                         cfg_write_i,
    input  wire logic        [CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic signed [COEFF_W-1:0]    cfg_wdata_i,
    output logic                              coeff_we_i_o,
    output logic                              coeff_we_q_o,
    output logic             [TAP_ADDR_W-1:0] coeff_addr_i_o,
    output logic             [TAP_ADDR_W-1:0] coeff_addr_q_o,
    output logic signed      [COEFF_W-1:0]    coeff_wdata_o,
    input  wire logic signed [COEFF_W-1:0]    rdata_i_i,
    input  wire logic signed [COEFF_W-1:0]    rdata_q_i,
    output logic signed      [COEFF_W-1:0]    cfg_rdata_o,
    output logic                              cfg_rvalid_o
);

    logic                  in_i_win;
    logic                  in_q_win;
    logic                  rd_req;
    logic [CFG_ADDR_W-1:0] off_i;
    logic [CFG_ADDR_W-1:0] off_q;

    // Window hits
    assign in_i_win = (cfg_addr_i >= CFG_ADDR_W'(I_COEFF_BASE)) &&
                      (cfg_addr_i <  CFG_ADDR_W'(I_COEFF_BASE + NUM_TAPS));
    assign in_q_win = (cfg_addr_i >= CFG_ADDR_W'(Q_COEFF_BASE)) &&
                      (cfg_addr_i <  CFG_ADDR_W'(Q_COEFF_BASE + NUM_TAPS));

    // Local tap index inside each window
    assign off_i          = cfg_addr_i - CFG_ADDR_W'(I_COEFF_BASE);
    assign off_q          = cfg_addr_i - CFG_ADDR_W'(Q_COEFF_BASE);
    assign coeff_addr_i_o = off_i[TAP_ADDR_W-1:0];
    assign coeff_addr_q_o = off_q[TAP_ADDR_W-1:0];

    // Writes outside both windows fall away here
    assign coeff_we_i_o  = cfg_valid_i && cfg_write_i && in_i_win;
    assign coeff_we_q_o  = cfg_valid_i && cfg_write_i && in_q_win;
    assign coeff_wdata_o = cfg_wdata_i;

    assign rd_req = cfg_valid_i && !cfg_write_i;

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            cfg_rvalid_o <= 1'b0;
        end else begin
            cfg_rvalid_o <= rd_req;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge clk) begin
        if (rd_req) begin
            cfg_rdata_o <= in_i_win ? rdata_i_i : (in_q_win ? rdata_q_i : '0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    // Symbol and upsampled sample width, signed
    localparam int SYM_W = 4;

    // Signed filter coefficient
    localparam int COEFF_W = 8;

    // Taps per filter and the local coefficient address
    localparam int NUM_TAPS = 16;
    localparam int TAP_ADDR_W = 4;

    // Filter accumulator, wide enough for sixteen full-scale products
    localparam int ACC_W = 16;

    // DAC word is the top of the accumulator, low bits dropped
    localparam int DAC_W = 10;

    // Global coefficient address space
    localparam int CFG_ADDR_W = 10;
    localparam int I_COEFF_BASE = 128;
    localparam int Q_COEFF_BASE = 256;

    // Upsampling rate input
    localparam int RATE_W = 4;

    // Product stage plus sum stage
    localparam int FIR_LATENCY = 2;

    // Delay line flush plus pipeline plus margin before DAC goes live
    localparam int WARMUP_CYCLES = NUM_TAPS + FIR_LATENCY + 2;
    localparam int WARM_CNT_W = $clog2(WARMUP_CYCLES + 1);

endpackage

`default_nettype wire

// ==== logic/dsp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_top import dsp_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         sym_valid_i,
    output logic                              sym_ready_o,
    input  wire logic signed [SYM_W-1:0]      sym_i_i,
    input  wire logic signed [SYM_W-1:0]      sym_q_i,
    input  wire logic        [RATE_W-1:0]     sample_rate_i,
    input  wire logic                         cfg_valid_i,
    input  wire logic                         cfg_write_i,
    input  wire logic        [CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic signed [COEFF_W-1:0]    cfg_wdata_i,
    output logic signed      [COEFF_W-1:0]    cfg_rdata_o,
    output logic                              cfg_rvalid_o,
    output logic signed      [DAC_W-1:0]      dac_i_o,
    output logic signed      [DAC_W-1:0]      dac_q_o,
    output logic                              dac_valid_o
);

    logic                         rst_n_sync_wire;
    logic signed [SYM_W-1:0]      smp_i;
    logic signed [SYM_W-1:0]      smp_q;
    logic                         coeff_we_i;
    logic                         coeff_we_q;
    logic        [TAP_ADDR_W-1:0] coeff_addr_i;
    logic        [TAP_ADDR_W-1:0] coeff_addr_q;
    logic signed [COEFF_W-1:0]    coeff_wdata;
    logic signed [COEFF_W-1:0]    rdata_i;
    logic signed [COEFF_W-1:0]    rdata_q;
    logic signed [ACC_W-1:0]      fir_i;
    logic signed [ACC_W-1:0]      fir_q;

    reset_sync u_reset_sync (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .rst_n_sync_o (rst_n_sync_wire)
    );

    symbol_upsampler u_upsampler (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sym_valid_i     (sym_valid_i),
        .sym_ready_o     (sym_ready_o),
        .sym_i_i         (sym_i_i),
        .sym_q_i         (sym_q_i),
        .sample_rate_i   (sample_rate_i),
        .smp_i_o         (smp_i),
        .smp_q_o         (smp_q)
    );

    coeff_bus_decode u_coeff_dec (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .cfg_valid_i     (cfg_valid_i),
        .cfg_write_i     (cfg_write_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .coeff_we_i_o    (coeff_we_i),
        .coeff_we_q_o    (coeff_we_q),
        .coeff_addr_i_o  (coeff_addr_i),
        .coeff_addr_q_o  (coeff_addr_q),
        .coeff_wdata_o   (coeff_wdata),
        .rdata_i_i       (rdata_i),
        .rdata_q_i       (rdata_q),
        .cfg_rdata_o     (cfg_rdata_o),
        .cfg_rvalid_o    (cfg_rvalid_o)
    );

    // In-phase filter
    fir_filter u_fir_i (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .smp_i           (smp_i),
        .coeff_we_i      (coeff_we_i),
        .coeff_addr_i    (coeff_addr_i),
        .coeff_wdata_i   (coeff_wdata),
        .coeff_rdata_o   (rdata_i),
        .fir_out_o       (fir_i)
    );

    // Quadrature filter
    fir_filter u_fir_q (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .smp_i           (smp_q),
        .coeff_we_i      (coeff_we_q),
        .coeff_addr_i    (coeff_addr_q),
        .coeff_wdata_i   (coeff_wdata),
        .coeff_rdata_o   (rdata_q),
        .fir_out_o       (fir_q)
    );

    iq_output_stage u_out_stage (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .fir_i_i         (fir_i),
        .fir_q_i         (fir_q),
        .dac_i_o         (dac_i_o),
        .dac_q_o         (dac_q_o),
        .dac_valid_o     (dac_valid_o)
    );

endmodule

`default_nettype wire

// ==== logic/fir_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_filter import dsp_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n_sync_wire,
    input  wire logic signed [SYM_W-1:0]      smp_i,
    input  wire logic                         coeff_we_i,
    input  wire logic        [TAP_ADDR_W-1:0] coeff_addr_i,
    input  wire logic signed [COEFF_W-1:0]    coeff_wdata_i,
    output logic signed      [COEFF_W-1:0]    coeff_rdata_o,
    output logic signed      [ACC_W-1:0]      fir_out_o
);

    logic signed [SYM_W-1:0]         taps    [NUM_TAPS];
    logic signed [SYM_W-1:0]         dly_q   [NUM_TAPS-1];
    logic signed [SYM_W+COEFF_W-1:0] prod_q  [NUM_TAPS];
    logic signed [COEFF_W-1:0]       coeff_q [NUM_TAPS];
    logic signed [ACC_W-1:0]         sum_c;
    logic signed [ACC_W-1:0]         acc_q;

    // Tap 0 is the incoming sample, the rest come from the delay line
    always_comb begin
        taps[0] = smp_i;
        for (int k = 1; k < NUM_TAPS; k++) begin
            taps[k] = dly_q[k-1];
        end
    end

    always_ff @(posedge clk) begin
        dly_q[0] <= smp_i;
        for (int k = 1; k < NUM_TAPS - 1; k++) begin
            dly_q[k] <= dly_q[k-1];
        end
    end

    // Stage 1: one registered product per tap
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_TAPS; k++) begin
            prod_q[k] <= taps[k] * coeff_q[k];
        end
    end

    // Stage 2: signed sum of the products
    always_comb begin
        sum_c = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum_c = sum_c + ACC_W'(prod_q[k]);
        end
    end

    always_ff @(posedge clk) begin
        acc_q <= sum_c;
    end

    assign fir_out_o = acc_q;

    // Coefficient register file, cleared by reset
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                coeff_q[k] <= '0;
            end
        end else if (coeff_we_i) begin
            coeff_q[coeff_addr_i] <= coeff_wdata_i;
        end
    end

    // Read back straight from the local address
    assign coeff_rdata_o = coeff_q[coeff_addr_i];

    a_we_addr_known: assert property (@(posedge clk) disable iff (!rst_n_sync_wire)
        coeff_we_i |-> !$isunknown(coeff_addr_i));

endmodule

`default_nettype wire

// ==== logic/iq_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_output_stage import dsp_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n_sync_wire,
    input  wire logic signed [ACC_W-1:0] fir_i_i,
    input  wire logic signed [ACC_W-1:0] fir_q_i,
    output logic signed      [DAC_W-1:0] dac_i_o,
    output logic signed      [DAC_W-1:0] dac_q_o,
    output logic                         dac_valid_o
);

    logic [WARM_CNT_W-1:0] warm_cnt_q;
    logic                  live;

    assign live = (warm_cnt_q == WARM_CNT_W'(WARMUP_CYCLES));

    // Saturating count of cycles since reset release
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            warm_cnt_q <= '0;
        end else if (!live) begin
            warm_cnt_q <= warm_cnt_q + 1'b1;
        end
    end

    // Truncate to the top bits, zero while the filters flush
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            dac_i_o     <= '0;
            dac_q_o     <= '0;
            dac_valid_o <= 1'b0;
        end else begin
            dac_valid_o <= live;
            dac_i_o     <= live ? fir_i_i[ACC_W-1 -: DAC_W] : '0;
            dac_q_o     <= live ? fir_q_i[ACC_W-1 -: DAC_W] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
    input  wire logic clk,
    input  wire logic rst_n_i,
    output logic      rst_n_sync_o
);

    logic meta_q;

    // Assert at once, release two edges later
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q       <= 1'b0;
            rst_n_sync_o <= 1'b0;
        end else begin
            meta_q       <= 1'b1;
            rst_n_sync_o <= meta_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/symbol_upsampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module symbol_upsampler import dsp_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst_n_sync_wire,
    input  wire logic                     sym_valid_i,
    output logic                          sym_ready_o,
    input  wire logic signed [SYM_W-1:0]  sym_i_i,
    input  wire logic signed [SYM_W-1:0]  sym_q_i,
    input  wire logic        [RATE_W-1:0] sample_rate_i,
    output logic signed      [SYM_W-1:0]  smp_i_o,
    output logic signed      [SYM_W-1:0]  smp_q_o
);

    logic [RATE_W-1:0] rate_q;
    logic [RATE_W-1:0] phase_q;
    logic              busy_q;
    logic              last_phase;
    logic              sym_fire;
    logic [RATE_W-1:0] rate_in;

    assign last_phase  = busy_q && (phase_q == rate_q - 1'b1);
    assign sym_ready_o = !busy_q || last_phase;
    assign sym_fire    = sym_valid_i && sym_ready_o;

    // Rate 0 behaves as rate 1
    assign rate_in = (sample_rate_i == '0) ? RATE_W'(1) : sample_rate_i;

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            rate_q  <= RATE_W'(1);
            phase_q <= '0;
            busy_q  <= 1'b0;
            smp_i_o <= '0;
            smp_q_o <= '0;
        end else if (sym_fire) begin
            // New period starts with the symbol itself
            rate_q  <= rate_in;
            phase_q <= '0;
            busy_q  <= 1'b1;
            smp_i_o <= sym_i_i;
            smp_q_o <= sym_q_i;
        end else begin
            smp_i_o <= '0;
            smp_q_o <= '0;
            if (last_phase) begin
                // Underrun, idle on zeros until the next symbol
                busy_q  <= 1'b0;
                phase_q <= '0;
            end else if (busy_q) begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    a_phase_in_range: assert property (@(posedge clk) disable iff (!rst_n_sync_wire)
        phase_q < rate_q);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int CLK_PERIOD_NS = 100,
    parameter int RESET_CYCLES  = 4
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low over the first rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/tb_dsp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_top import dsp_pkg::*; ();

    // Sync stages, warm-up count, then the output register
    localparam int SYNC_STAGES  = 2;
    localparam int LIVE_DELAY   = SYNC_STAGES + WARMUP_CYCLES + 1;
    // Upsampler sample to DAC word
    localparam int PIPE_DLY     = FIR_LATENCY + 1;
    localparam int HIST_LEN     = NUM_TAPS + PIPE_DLY;
    localparam int ACC_LSB      = ACC_W - DAC_W;
    localparam int IMPULSE_RATE = 4;
    localparam int STREAM_RATE  = 3;
    localparam int STREAM_SYMS  = 40;
    localparam int GAP_SYMS     = 30;
    localparam int NUM_OUTSIDE  = 6;
    localparam int ACCESS_CYC   = 3;
    localparam int TEST_CYCLES  = (LIVE_DELAY + 8) + 2 * NUM_TAPS * ACCESS_CYC
                                + (4 * NUM_TAPS + 2 * NUM_OUTSIDE) * ACCESS_CYC
                                + 2 * ACCESS_CYC + 2 * (PIPE_DLY + NUM_TAPS + 10)
                                + STREAM_SYMS * STREAM_RATE + HIST_LEN + 10
                                + GAP_SYMS * 16 + HIST_LEN + 10;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

    logic                         clk;
    logic                         rst_n;
    logic                         sym_valid;
    logic                         sym_ready;
    logic signed [SYM_W-1:0]      sym_i;
    logic signed [SYM_W-1:0]      sym_q;
    logic        [RATE_W-1:0]     sample_rate;
    logic                         cfg_valid;
    logic                         cfg_write;
    logic        [CFG_ADDR_W-1:0] cfg_addr;
    logic signed [COEFF_W-1:0]    cfg_wdata;
    logic signed [COEFF_W-1:0]    cfg_rdata;
    logic                         cfg_rvalid;
    logic signed [DAC_W-1:0]      dac_i;
    logic signed [DAC_W-1:0]      dac_q;
    logic                         dac_valid;

    // Expected coefficients and upsampled sample history, newest first
    logic signed [COEFF_W-1:0] coef_i [NUM_TAPS];
    logic signed [COEFF_W-1:0] coef_q [NUM_TAPS];
    logic signed [SYM_W-1:0]   hist_i [HIST_LEN];
    logic signed [SYM_W-1:0]   hist_q [HIST_LEN];
    int                        m_left;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;
    logic [31:0] lcg_state = 32'h89391a62;
    int          outside_addr [NUM_OUTSIDE] = '{0, I_COEFF_BASE - 1, I_COEFF_BASE + NUM_TAPS,
                                                Q_COEFF_BASE - 1, Q_COEFF_BASE + NUM_TAPS,
                                                (1 << CFG_ADDR_W) - 1};

    tb_clock_gen #(.CLK_PERIOD_NS(100), .RESET_CYCLES(4)) u_clock_gen (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    dsp_top i_dsp_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .sym_valid_i   (sym_valid),
        .sym_ready_o   (sym_ready),
        .sym_i_i       (sym_i),
        .sym_q_i       (sym_q),
        .sample_rate_i (sample_rate),
        .cfg_valid_i   (cfg_valid),
        .cfg_write_i   (cfg_write),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .cfg_rdata_o   (cfg_rdata),
        .cfg_rvalid_o  (cfg_rvalid),
        .dac_i_o       (dac_i),
        .dac_q_o       (dac_q),
        .dac_valid_o   (dac_valid)
    );

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic bit in_window(input int addr, input int base);
        return (addr >= base) && (addr < base + NUM_TAPS);
    endfunction

    function automatic logic signed [COEFF_W-1:0] stored_coeff(input int addr);
        if (in_window(addr, I_COEFF_BASE)) begin
            return coef_i[addr - I_COEFF_BASE];
        end
        if (in_window(addr, Q_COEFF_BASE)) begin
            return coef_q[addr - Q_COEFF_BASE];
        end
        return '0;
    endfunction

    // Expected DAC word: FIR sum over the history, floor to the top bits
    function automatic logic signed [DAC_W-1:0] ref_dac(input bit q_chan);
        int acc;
        acc = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            if (q_chan) begin
                acc += int'(coef_q[k]) * int'(hist_q[k + PIPE_DLY]);
            end else begin
                acc += int'(coef_i[k]) * int'(hist_i[k + PIPE_DLY]);
            end
        end
        return DAC_W'(acc >>> ACC_LSB);
    endfunction

    task automatic cfg_write_word(input int addr, input logic signed [COEFF_W-1:0] data);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_write <= 1'b1;
        cfg_addr  <= CFG_ADDR_W'(addr);
        cfg_wdata <= data;
        @(posedge clk);
        cfg_valid <= 1'b0;
        cfg_write <= 1'b0;
        if (in_window(addr, I_COEFF_BASE)) begin
            coef_i[addr - I_COEFF_BASE] = data;
        end
        if (in_window(addr, Q_COEFF_BASE)) begin
            coef_q[addr - Q_COEFF_BASE] = data;
        end
    endtask

    task automatic cfg_read_check(input int addr);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_write <= 1'b0;
        cfg_addr  <= CFG_ADDR_W'(addr);
        // Request taken on this edge
        @(posedge clk);
        cfg_valid <= 1'b0;
        if (cfg_rvalid !== 1'b0) begin
            $display("FAIL cfg_rvalid_o in request cycle, addr %h: got %h expected 0",
                     addr, cfg_rvalid);
            errors++;
        end
        @(posedge clk);
        if (cfg_rvalid !== 1'b1) begin
            $display("FAIL cfg_rvalid_o one cycle after request, addr %h: got %h expected 1",
                     addr, cfg_rvalid);
            errors++;
        end
        if (cfg_rdata !== stored_coeff(addr)) begin
            $display("FAIL cfg_rdata_o addr %h: got %h expected %h",
                     addr, cfg_rdata, stored_coeff(addr));
            errors++;
        end
    endtask

    // Called at a rising edge, returns at the handshake edge with valid still high
    task automatic send_symbol(input logic signed [SYM_W-1:0] si,
                               input logic signed [SYM_W-1:0] sq,
                               input logic [RATE_W-1:0] rate, output int wait_cycles);
        sym_valid   <= 1'b1;
        sym_i       <= si;
        sym_q       <= sq;
        sample_rate <= rate;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (sym_ready !== 1'b1);
    endtask

    task automatic impulse_check(input logic signed [SYM_W-1:0] si,
                                 input logic signed [SYM_W-1:0] sq);
        int                      wc;
        logic signed [DAC_W-1:0] want_i;
        logic signed [DAC_W-1:0] want_q;
        @(posedge clk);
        send_symbol(si, sq, RATE_W'(IMPULSE_RATE), wc);
        sym_valid <= 1'b0;
        repeat (PIPE_DLY) @(posedge clk);
        if (dac_i !== '0 || dac_q !== '0) begin
            $display("FAIL dac_i_o/dac_q_o before impulse: got %h/%h expected 0", dac_i, dac_q);
            errors++;
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            @(posedge clk);
            want_i = DAC_W'((int'(coef_i[k]) * int'(si)) >>> ACC_LSB);
            want_q = DAC_W'((int'(coef_q[k]) * int'(sq)) >>> ACC_LSB);
            if (dac_i !== want_i) begin
                $display("FAIL dac_i_o impulse tap %0d: got %h expected %h", k, dac_i, want_i);
                errors++;
            end
            if (dac_q !== want_q) begin
                $display("FAIL dac_q_o impulse tap %0d: got %h expected %h", k, dac_q, want_q);
                errors++;
            end
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic begin_test();
        test_err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", tests_run, name, errors - test_err_base);
        end
    endtask

    // Upsampler model and per-cycle DAC compare
    initial begin : compare_proc
        int                      cycles;
        logic                    exp_valid;
        logic                    exp_ready;
        logic signed [DAC_W-1:0] exp_i;
        logic signed [DAC_W-1:0] exp_q;
        logic signed [SYM_W-1:0] nxt_i;
        logic signed [SYM_W-1:0] nxt_q;
        cycles = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            cycles++;
            exp_valid = (cycles > LIVE_DELAY);
            exp_ready = (m_left == 0);
            exp_i = exp_valid ? ref_dac(1'b0) : '0;
            exp_q = exp_valid ? ref_dac(1'b1) : '0;
            if (dac_valid !== exp_valid) begin
                $display("FAIL dac_valid_o cycle %0d: got %h expected %h",
                         cycles, dac_valid, exp_valid);
                errors++;
            end
            if (dac_i !== exp_i) begin
                $display("FAIL dac_i_o cycle %0d: got %h expected %h", cycles, dac_i, exp_i);
                errors++;
            end
            if (dac_q !== exp_q) begin
                $display("FAIL dac_q_o cycle %0d: got %h expected %h", cycles, dac_q, exp_q);
                errors++;
            end
            if (sym_ready !== exp_ready) begin
                $display("FAIL sym_ready_o cycle %0d: got %h expected %h",
                         cycles, sym_ready, exp_ready);
                errors++;
            end
            // A transfer starts a period of rate samples, else zeros
            if (sym_valid === 1'b1 && exp_ready) begin
                nxt_i  = sym_i;
                nxt_q  = sym_q;
                m_left = (sample_rate == '0) ? 0 : int'(sample_rate) - 1;
            end else begin
                nxt_i = '0;
                nxt_q = '0;
                if (m_left > 0) begin
                    m_left--;
                end
            end
            for (int j = HIST_LEN - 1; j > 0; j--) begin
                hist_i[j] = hist_i[j-1];
                hist_q[j] = hist_q[j-1];
            end
            hist_i[0] = nxt_i;
            hist_q[0] = nxt_q;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main_proc
        int                      wc;
        int                      gap;
        int                      low_cycles;
        logic signed [SYM_W-1:0] si;
        logic signed [SYM_W-1:0] sq;
        logic        [RATE_W-1:0] rate;
        sym_valid    = 1'b0;
        sym_i        = '0;
        sym_q        = '0;
        sample_rate  = '0;
        cfg_valid    = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_left       = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_i[k] = '0;
            coef_q[k] = '0;
        end
        for (int j = 0; j < HIST_LEN; j++) begin
            hist_i[j] = '0;
            hist_q[j] = '0;
        end

        wait (rst_n === 1'b1);
        begin_test();
        low_cycles = 0;
        @(posedge clk);
        while (dac_valid !== 1'b1 && low_cycles < LIVE_DELAY + 8) begin
            low_cycles++;
            if (sym_ready !== 1'b1) begin
                $display("FAIL sym_ready_o during warm-up: got %h expected 1", sym_ready);
                errors++;
            end
            @(posedge clk);
        end
        if (low_cycles != LIVE_DELAY) begin
            $display("FAIL dac_valid_o low cycles after reset: got %h expected %h",
                     low_cycles, LIVE_DELAY);
            errors++;
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_read_check(I_COEFF_BASE + k);
            cfg_read_check(Q_COEFF_BASE + k);
        end
        end_test("reset and warm-up");

        begin_test();
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write_word(I_COEFF_BASE + k, COEFF_W'(next_random()));
            cfg_write_word(Q_COEFF_BASE + k, COEFF_W'(next_random()));
        end
        for (int n = 0; n < NUM_OUTSIDE; n++) begin
            cfg_write_word(outside_addr[n], COEFF_W'(next_random()));
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_read_check(I_COEFF_BASE + k);
            cfg_read_check(Q_COEFF_BASE + k);
        end
        for (int n = 0; n < NUM_OUTSIDE; n++) begin
            cfg_read_check(outside_addr[n]);
        end
        end_test("coefficient write and read-back");

        begin_test();
        // Large first taps make the start of the response visible
        cfg_write_word(I_COEFF_BASE, 8'sh7f);
        cfg_write_word(Q_COEFF_BASE, 8'sh81);
        impulse_check(4'sd7, 4'sd0);
        impulse_check(4'sd0, -4'sd8);
        end_test("impulse response at rate 4");

        begin_test();
        @(posedge clk);
        for (int s = 0; s < STREAM_SYMS; s++) begin
            si = SYM_W'(next_random());
            sq = SYM_W'(next_random());
            send_symbol(si, sq, RATE_W'(STREAM_RATE), wc);
            if (s > 0 && wc != STREAM_RATE) begin
                $display("FAIL sym_ready_o handshake spacing: got %h expected %h",
                         wc, STREAM_RATE);
                errors++;
            end
        end
        sym_valid <= 1'b0;
        repeat (HIST_LEN + 8) @(posedge clk);
        end_test("back-to-back stream at rate 3");

        begin_test();
        @(posedge clk);
        for (int s = 0; s < GAP_SYMS; s++) begin
            gap = int'(next_random() % 16'd8);
            if (gap > 0) begin
                sym_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            if (s % 5 == 0) begin
                rate = '0;
            end else begin
                rate = RATE_W'(1 + next_random() % 16'd5);
            end
            si = SYM_W'(next_random());
            sq = SYM_W'(next_random());
            send_symbol(si, sq, rate, wc);
        end
        sym_valid <= 1'b0;
        repeat (HIST_LEN + 8) @(posedge clk);
        end_test("valid gaps and rate changes");

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
